//--- Makefile
SIM = obj_dir/VinterlockTb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module interlockTb -f filelist.f -Mdir obj_dir

run: compile
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "ALL CHECKS PASSED"

clean:
	rm -rf obj_dir

//--- filelist.f
logic/isaPkg.sv
logic/pipePkg.sv
logic/issueQueue.sv
logic/operandDecoder.sv
logic/resultTracker.sv
logic/mulDivTimer.sv
logic/hazardControl.sv
logic/interlockTop.sv
tests/interlockTb.sv

//--- logic/hazardControl.sv
`timescale 1ns/1ps

module hazardControl import isaPkg::*, pipePkg::*; (
    input  logic   headValid,
    input  decodeT dec,
    input  stageT  exeStage,
    input  stageT  memStage,
    input  logic   mulBusy,
    input  logic   mulStart,
    output logic   issue,
    output logic   stall
);

    logic rsExeHazard;
    logic rsMemHazard;
    logic rtExeHazard;
    logic rtMemHazard;
    logic usesHiLo;
    logic mulDivHazard;

    // Producer still too far from its result for this consumer
    function automatic logic srcHazard(regIdxT src, timeT useTime, stageT st);
        logic match;
        match = (src != '0) && (src == st.dest);
        return match && st.valid && st.regWrite && (useTime < st.resTime);
    endfunction

    ////////////////////
    // Register operands

    assign rsExeHazard = srcHazard(dec.rs, dec.rsUse, exeStage);
    assign rsMemHazard = srcHazard(dec.rs, dec.rsUse, memStage);
    assign rtExeHazard = srcHazard(dec.rt, dec.rtUse, exeStage);
    assign rtMemHazard = srcHazard(dec.rt, dec.rtUse, memStage);

    ////////////////////
    // HI/LO and the multiplier

    assign usesHiLo = (dec.cls == ClassMulDiv) ||
                      (dec.cls == ClassHiLoRead) ||
                      (dec.cls == ClassHiLoWrite);

    // mulStart covers the cycle before the counter loads
    assign mulDivHazard = usesHiLo && (mulBusy || mulStart);

    assign stall = headValid && (rsExeHazard || rsMemHazard ||
                                 rtExeHazard || rtMemHazard ||
                                 mulDivHazard);

    assign issue = headValid && !stall;

endmodule

//--- logic/interlockTop.sv
`timescale 1ns/1ps

module interlockTop import isaPkg::*, pipePkg::*; #(
    parameter int QueueDepth = 4,
    parameter int MultCycles = 5,
    parameter int DivCycles  = 10
) (
    input  logic  clk,
    input  logic  rstN,
    input  logic  instrValid,
    input  instrT instr,
    output logic  creditReturn,
    output logic  issueValid,
    output instrT issueInstr,
    output logic  retireValid,
    output instrT retireInstr
);

    logic   headValid;
    decodeT dec;
    stageT  exeStage;
    stageT  memStage;
    logic   mulBusy;
    logic   mulStart;

    // Queue head doubles as the issuing instruction
    issueQueue #(
        .QueueDepth(QueueDepth)
    ) queue_i (
        .clk         (clk),
        .rstN        (rstN),
        .instrValid  (instrValid),
        .instr       (instr),
        .pop         (issueValid),
        .headValid   (headValid),
        .headInstr   (issueInstr),
        .creditReturn(creditReturn)
    );

    operandDecoder decoder_i (
        .headInstr(issueInstr),
        .dec      (dec)
    );

    resultTracker tracker_i (
        .clk        (clk),
        .rstN       (rstN),
        .issue      (issueValid),
        .dec        (dec),
        .headInstr  (issueInstr),
        .exeStage   (exeStage),
        .memStage   (memStage),
        .retireValid(retireValid),
        .retireInstr(retireInstr)
    );

    mulDivTimer #(
        .MultCycles(MultCycles),
        .DivCycles (DivCycles)
    ) timer_i (
        .clk     (clk),
        .rstN    (rstN),
        .exeStage(exeStage),
        .mulBusy (mulBusy),
        .mulStart(mulStart)
    );

    hazardControl control_i (
        .headValid(headValid),
        .dec      (dec),
        .exeStage (exeStage),
        .memStage (memStage),
        .mulBusy  (mulBusy),
        .mulStart (mulStart),
        .issue    (issueValid),
        .stall    ()
    );

endmodule

//--- logic/isaPkg.sv
package isaPkg;

    typedef logic [31:0] instrT;
    typedef logic [4:0]  regIdxT;
    typedef logic [5:0]  opcodeT;
    typedef logic [5:0]  functT;

    // Cycles until a value is needed or produced
    typedef logic [1:0]  timeT;

    // Field layout shared by R and I formats
    typedef struct packed {
        opcodeT     op;
        regIdxT     rs;
        regIdxT     rt;
        regIdxT     rd;
        logic [4:0] shamt;
        functT      funct;
    } rFieldsT;

    localparam regIdxT LinkReg = 5'd31;

    ////////////////////
    // Opcodes
    localparam opcodeT OpSpecial = 6'h00;
    localparam opcodeT OpJ       = 6'h02;
    localparam opcodeT OpJal     = 6'h03;
    localparam opcodeT OpBeq     = 6'h04;
    localparam opcodeT OpBne     = 6'h05;
    localparam opcodeT OpAddi    = 6'h08;
    localparam opcodeT OpAndi    = 6'h0c;
    localparam opcodeT OpOri     = 6'h0d;
    localparam opcodeT OpLui     = 6'h0f;
    localparam opcodeT OpLb      = 6'h20;
    localparam opcodeT OpLh      = 6'h21;
    localparam opcodeT OpLw      = 6'h23;
    localparam opcodeT OpSb      = 6'h28;
    localparam opcodeT OpSh      = 6'h29;
    localparam opcodeT OpSw      = 6'h2b;

    ////////////////////
    // Function codes under OpSpecial
    localparam functT FnJr    = 6'h08;
    localparam functT FnMfhi  = 6'h10;
    localparam functT FnMthi  = 6'h11;
    localparam functT FnMflo  = 6'h12;
    localparam functT FnMtlo  = 6'h13;
    localparam functT FnMult  = 6'h18;
    localparam functT FnMultu = 6'h19;
    localparam functT FnDiv   = 6'h1a;
    localparam functT FnDivu  = 6'h1b;
    localparam functT FnAdd   = 6'h20;
    localparam functT FnSub   = 6'h22;
    localparam functT FnAnd   = 6'h24;
    localparam functT FnOr    = 6'h25;
    localparam functT FnSlt   = 6'h2a;
    localparam functT FnSltu  = 6'h2b;
    // Subtract with borrow, local extension
    localparam functT FnSbc   = 6'h2e;

endpackage

//--- logic/issueQueue.sv
`timescale 1ns/1ps

module issueQueue import isaPkg::*; #(
    parameter int QueueDepth = 4
) (
    input  logic  clk,
    input  logic  rstN,
    input  logic  instrValid,
    input  instrT instr,
    input  logic  pop,
    output logic  headValid,
    output instrT headInstr,
    output logic  creditReturn
);

    localparam int PtrWidth   = (QueueDepth > 1) ? $clog2(QueueDepth) : 1;
    localparam int CountWidth = $clog2(QueueDepth + 1);

    typedef logic [PtrWidth-1:0] ptrT;

    instrT                 mem [QueueDepth];
    ptrT                   wrPtr;
    ptrT                   rdPtr;
    logic [CountWidth-1:0] count;

    function automatic ptrT nextPtr(ptrT p);
        return (p == ptrT'(QueueDepth - 1)) ? '0 : p + 1'b1;
    endfunction

    always_ff @(posedge clk) begin
        if (instrValid) begin
            mem[wrPtr] <= instr;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            wrPtr        <= '0;
            rdPtr        <= '0;
            count        <= '0;
            creditReturn <= 1'b0;
        end else begin
            if (instrValid) begin
                wrPtr <= nextPtr(wrPtr);
            end
            if (pop) begin
                rdPtr <= nextPtr(rdPtr);
            end
            // Sender credits make overflow impossible
            case ({instrValid, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            creditReturn <= pop;
        end
    end

    // Head entry is the decode stage
    assign headValid = (count != '0);
    assign headInstr = mem[rdPtr];

endmodule

//--- logic/mulDivTimer.sv
`timescale 1ns/1ps

module mulDivTimer import isaPkg::*, pipePkg::*; #(
    parameter int MultCycles = 5,
    parameter int DivCycles  = 10
) (
    input  logic  clk,
    input  logic  rstN,
    input  stageT exeStage,
    output logic  mulBusy,
    output logic  mulStart
);

    localparam int MaxCycles  = (DivCycles > MultCycles) ? DivCycles : MultCycles;
    localparam int CountWidth = $clog2(MaxCycles + 1);

    rFieldsT               exeFields;
    logic                  isDiv;
    logic [CountWidth-1:0] count;

    assign exeFields = exeStage.instr;
    assign mulStart  = exeStage.valid && (exeStage.cls == ClassMulDiv);
    assign isDiv     = (exeFields.funct == FnDiv) || (exeFields.funct == FnDivu);

    // Execute cycle is the first cycle of the latency
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            count <= '0;
        end else if (mulStart) begin
            if (isDiv) begin
                count <= CountWidth'(DivCycles - 1);
            end else begin
                count <= CountWidth'(MultCycles - 1);
            end
        end else if (count != '0) begin
            count <= count - 1'b1;
        end
    end

    assign mulBusy = (count != '0);

endmodule

//--- logic/operandDecoder.sv
`timescale 1ns/1ps

module operandDecoder import isaPkg::*, pipePkg::*; (
    input  instrT  headInstr,
    output decodeT dec
);

    rFieldsT f;

    assign f = headInstr;

    always_comb begin
        dec     = '0;
        dec.cls = ClassOther;
        case (f.op)
            OpSpecial: begin
                case (f.funct)
                    FnAdd, FnSub, FnAnd, FnOr, FnSlt, FnSltu, FnSbc: begin
                        dec.rs       = f.rs;
                        dec.rsUse    = 2'd1;
                        dec.rt       = f.rt;
                        dec.rtUse    = 2'd1;
                        dec.dest     = f.rd;
                        dec.regWrite = 1'b1;
                        dec.resTime  = 2'd1;
                        dec.cls      = ClassAlu;
                    end
                    FnMult, FnMultu, FnDiv, FnDivu: begin
                        dec.rs    = f.rs;
                        dec.rsUse = 2'd1;
                        dec.rt    = f.rt;
                        dec.rtUse = 2'd1;
                        dec.cls   = ClassMulDiv;
                    end
                    FnMfhi, FnMflo: begin
                        dec.dest     = f.rd;
                        dec.regWrite = 1'b1;
                        dec.resTime  = 2'd1;
                        dec.cls      = ClassHiLoRead;
                    end
                    FnMthi, FnMtlo: begin
                        dec.rs    = f.rs;
                        dec.rsUse = 2'd1;
                        dec.cls   = ClassHiLoWrite;
                    end
                    FnJr: begin
                        // Target needed at decode
                        dec.rs  = f.rs;
                        dec.cls = ClassJump;
                    end
                    default: dec.cls = ClassOther;
                endcase
            end
            OpOri, OpAddi, OpAndi: begin
                dec.rs       = f.rs;
                dec.rsUse    = 2'd1;
                dec.dest     = f.rt;
                dec.regWrite = 1'b1;
                dec.resTime  = 2'd1;
                dec.cls      = ClassAlu;
            end
            OpLui: begin
                dec.dest     = f.rt;
                dec.regWrite = 1'b1;
                dec.resTime  = 2'd1;
                dec.cls      = ClassAlu;
            end
            OpSw, OpSb, OpSh: begin
                dec.rs    = f.rs;
                dec.rsUse = 2'd1;
                // Store data only needed in memory
                dec.rt    = f.rt;
                dec.rtUse = 2'd2;
                dec.cls   = ClassStore;
            end
            OpLw, OpLb, OpLh: begin
                dec.rs       = f.rs;
                dec.rsUse    = 2'd1;
                dec.dest     = f.rt;
                dec.regWrite = 1'b1;
                dec.resTime  = 2'd2;
                dec.cls      = ClassLoad;
            end
            OpBeq, OpBne: begin
                dec.rs  = f.rs;
                dec.rt  = f.rt;
                dec.cls = ClassBranch;
            end
            OpJ: dec.cls = ClassJump;
            OpJal: begin
                dec.dest     = LinkReg;
                dec.regWrite = 1'b1;
                dec.resTime  = 2'd1;
                dec.cls      = ClassJump;
            end
            default: dec.cls = ClassOther;
        endcase
    end

endmodule

//--- logic/pipePkg.sv
package pipePkg;

    import isaPkg::*;

    typedef enum logic [3:0] {
        ClassAlu,
        ClassLoad,
        ClassStore,
        ClassBranch,
        ClassJump,
        ClassMulDiv,
        ClassHiLoRead,
        ClassHiLoWrite,
        ClassOther
    } instrClassT;

    // What decode knows about the head instruction
    typedef struct packed {
        regIdxT     rs;
        timeT       rsUse;
        regIdxT     rt;
        timeT       rtUse;
        regIdxT     dest;
        timeT       resTime;
        logic       regWrite;
        instrClassT cls;
    } decodeT;

    // One pipeline stage past decode
    typedef struct packed {
        logic       valid;
        instrT      instr;
        regIdxT     dest;
        logic       regWrite;
        timeT       resTime;
        instrClassT cls;
    } stageT;

endpackage

//--- logic/resultTracker.sv
`timescale 1ns/1ps

module resultTracker import isaPkg::*, pipePkg::*; (
    input  logic   clk,
    input  logic   rstN,
    input  logic   issue,
    input  decodeT dec,
    input  instrT  headInstr,
    output stageT  exeStage,
    output stageT  memStage,
    output logic   retireValid,
    output instrT  retireInstr
);

    stageT nextExe;
    stageT wbStage;

    // One stage older, result one cycle closer
    function automatic stageT age(stageT s);
        stageT aged;
        aged = s;
        if (aged.resTime != '0) begin
            aged.resTime = aged.resTime - 1'b1;
        end
        return aged;
    endfunction

    ////////////////////
    // Execute entry

    always_comb begin
        nextExe     = '0;
        nextExe.cls = ClassOther;
        if (issue) begin
            nextExe.valid    = 1'b1;
            nextExe.instr    = headInstr;
            nextExe.dest     = dec.dest;
            nextExe.regWrite = dec.regWrite;
            nextExe.resTime  = dec.resTime;
            nextExe.cls      = dec.cls;
        end
    end

    // Only decode stalls, so later stages always advance
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            exeStage <= '0;
            memStage <= '0;
            wbStage  <= '0;
        end else begin
            exeStage <= nextExe;
            memStage <= age(exeStage);
            wbStage  <= age(memStage);
        end
    end

    assign retireValid = wbStage.valid;
    assign retireInstr = wbStage.instr;

endmodule

//--- tests/interlockTb.sv
`timescale 1ns/1ps

module interlockTb import isaPkg::*;;

    localparam int QueueDepth  = 4;
    localparam int MultCycles  = 5;
    localparam int DivCycles   = 10;
    localparam int RandomCount = 200;
    localparam int TotalInstrs = 13 + RandomCount;
    localparam int CycleLimit  = 2 * TotalInstrs * (DivCycles + 4);

    logic  clk;
    logic  rstN;
    logic  instrValid;
    instrT instr;
    logic  creditReturn;
    logic  issueValid;
    instrT issueInstr;
    logic  retireValid;
    instrT retireInstr;

    int    cycle;
    int    credits;
    int    checks;
    int    errors;
    int    issuedCount;
    int    retiredCount;
    int    creditCount;
    int    lastIssue;
    int    mulReadyAt;
    int    readyAt [32];
    instrT prog [$];
    instrT sentInstr [$];
    int    sentArrival [$];
    instrT retInstr [$];
    int    retCycle [$];

    interlockTop #(
        .QueueDepth(QueueDepth),
        .MultCycles(MultCycles),
        .DivCycles (DivCycles)
    ) dut_i (
        .clk         (clk),
        .rstN        (rstN),
        .instrValid  (instrValid),
        .instr       (instr),
        .creditReturn(creditReturn),
        .issueValid  (issueValid),
        .issueInstr  (issueInstr),
        .retireValid (retireValid),
        .retireInstr (retireInstr)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    ////////////////////
    // Instruction builders

    function automatic instrT rType(int rs, int rt, int rd, functT fn);
        return {OpSpecial, 5'(rs), 5'(rt), 5'(rd), 5'd0, fn};
    endfunction

    function automatic instrT iType(opcodeT op, int rs, int rt);
        return {op, 5'(rs), 5'(rt), 16'h0040};
    endfunction

    function automatic instrT randomInstr();
        int a;
        int b;
        int c;
        a = $urandom_range(0, 3);
        b = $urandom_range(0, 3);
        c = $urandom_range(0, 3);
        case ($urandom_range(0, 13))
            0:       return rType(a, b, c, FnAdd);
            1:       return rType(a, b, c, FnSlt);
            2:       return iType(OpAddi, a, b);
            3:       return iType(OpLui, 0, b);
            4:       return iType(OpLw, a, b);
            5:       return iType(OpSw, a, b);
            6:       return iType(OpBeq, a, b);
            7:       return rType(a, b, 0, FnMult);
            8:       return rType(a, b, 0, FnDivu);
            9:       return rType(0, 0, c, FnMflo);
            10:      return rType(a, 0, 0, FnMthi);
            11:      return rType(a, 0, 0, FnJr);
            12:      return {OpJal, 26'h40};
            default: return iType(OpLh, a, b);
        endcase
    endfunction

    ////////////////////
    // Reference model of operand timing

    // Expected issue cycle of the head, from use times against older results
    function automatic int earliestIssue(instrT w, int arrival);
        rFieldsT f;
        int      rs;
        int      rt;
        int      rsUse;
        int      rtUse;
        int      e;
        logic    hiLo;
        f = w;
        rs = 0;
        rt = 0;
        rsUse = 1;
        rtUse = 1;
        hiLo = 1'b0;
        case (f.op)
            OpSpecial: begin
                if (f.funct inside {FnAdd, FnSub, FnAnd, FnOr, FnSlt, FnSltu, FnSbc}) begin
                    rs = f.rs;
                    rt = f.rt;
                end else if (f.funct inside {FnMult, FnMultu, FnDiv, FnDivu}) begin
                    rs = f.rs;
                    rt = f.rt;
                    hiLo = 1'b1;
                end else if (f.funct inside {FnMthi, FnMtlo}) begin
                    rs = f.rs;
                    hiLo = 1'b1;
                end else if (f.funct inside {FnMfhi, FnMflo}) begin
                    hiLo = 1'b1;
                end else if (f.funct == FnJr) begin
                    rs = f.rs;
                    rsUse = 0;
                end
            end
            OpAddi, OpAndi, OpOri, OpLw, OpLb, OpLh: rs = f.rs;
            OpSw, OpSb, OpSh: begin
                rs = f.rs;
                rt = f.rt;
                rtUse = 2;
            end
            OpBeq, OpBne: begin
                rs = f.rs;
                rt = f.rt;
                rsUse = 0;
                rtUse = 0;
            end
            default: ;
        endcase
        e = arrival;
        if (lastIssue + 1 > e) e = lastIssue + 1;
        if (rs != 0 && readyAt[rs] - rsUse > e) e = readyAt[rs] - rsUse;
        if (rt != 0 && readyAt[rt] - rtUse > e) e = readyAt[rt] - rtUse;
        // HI/LO free once the latency has run from the mult/div issue
        if (hiLo && mulReadyAt > e) e = mulReadyAt;
        return e;
    endfunction

    task automatic recordIssue(instrT w, int at);
        rFieldsT f;
        int      dest;
        int      res;
        f = w;
        dest = 0;
        res = 0;
        case (f.op)
            OpSpecial: begin
                if (f.funct inside {FnAdd, FnSub, FnAnd, FnOr, FnSlt, FnSltu, FnSbc,
                                    FnMfhi, FnMflo}) begin
                    dest = f.rd;
                    res = 1;
                end
                if (f.funct inside {FnMult, FnMultu}) mulReadyAt = at + MultCycles + 1;
                if (f.funct inside {FnDiv, FnDivu}) mulReadyAt = at + DivCycles + 1;
            end
            OpAddi, OpAndi, OpOri, OpLui: begin
                dest = f.rt;
                res = 1;
            end
            OpLw, OpLb, OpLh: begin
                dest = f.rt;
                res = 2;
            end
            OpJal: begin
                dest = 31;
                res = 1;
            end
            default: ;
        endcase
        if (dest != 0 && at + 1 + res > readyAt[dest]) readyAt[dest] = at + 1 + res;
        lastIssue = at;
    endtask

    task automatic checkValue(string name, logic [31:0] got, logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("ERROR %0t %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    ////////////////////
    // Monitor, sampled away from the driving edge

    always @(posedge clk) begin
        cycle = cycle + 1;
        if (cycle > CycleLimit) begin
            $display("Run did not finish within %0d cycles", CycleLimit);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    always @(negedge clk) begin
        if (!rstN || cycle <= 7) begin
            checkValue("creditReturn", creditReturn, 1'b0);
            checkValue("issueValid", issueValid, 1'b0);
            checkValue("retireValid", retireValid, 1'b0);
        end
        if (rstN) begin
            if (creditReturn) begin
                credits++;
                creditCount++;
            end
            if (instrValid) begin
                credits--;
                sentInstr.push_back(instr);
                sentArrival.push_back(cycle + 1);
            end
            checks++;
            assert (credits >= 0 && credits <= QueueDepth) else begin
                $display("Sender credit count left its range at %0t: %0d", $time, credits);
                errors++;
            end
            if (issueValid) begin
                if (sentInstr.size() == 0) begin
                    $display("Issue at %0t with nothing sent", $time);
                    errors++;
                end else begin
                    checkValue("issueInstr", issueInstr, sentInstr[0]);
                    checkValue("issueCycle", cycle,
                               earliestIssue(sentInstr[0], sentArrival[0]));
                    recordIssue(sentInstr[0], cycle);
                    retInstr.push_back(sentInstr[0]);
                    retCycle.push_back(cycle + 3);
                    void'(sentInstr.pop_front());
                    void'(sentArrival.pop_front());
                end
                issuedCount++;
            end
            if (retireValid) begin
                if (retInstr.size() == 0) begin
                    $display("Retire at %0t with nothing issued", $time);
                    errors++;
                end else begin
                    checkValue("retireInstr", retireInstr, retInstr[0]);
                    checkValue("retireCycle", cycle, retCycle[0]);
                    void'(retInstr.pop_front());
                    void'(retCycle.pop_front());
                end
                retiredCount++;
            end
        end
    end

    ////////////////////
    // Stimulus

    task automatic runProgram(string name);
        int errBefore;
        int target;
        errBefore = errors;
        target = retiredCount + prog.size();
        while (prog.size() > 0) begin
            @(posedge clk);
            if (credits > 0) begin
                instrValid <= 1'b1;
                instr <= prog.pop_front();
            end else begin
                instrValid <= 1'b0;
            end
        end
        @(posedge clk);
        instrValid <= 1'b0;
        while (retiredCount < target) @(posedge clk);
        repeat (2) @(posedge clk);
        $display("Test %s done, %0d errors", name, errors - errBefore);
    endtask

    initial begin
        rstN = 1'b0;
        instrValid = 1'b0;
        instr = '0;
        cycle = 0;
        credits = QueueDepth;
        checks = 0;
        errors = 0;
        issuedCount = 0;
        retiredCount = 0;
        creditCount = 0;
        lastIssue = -10;
        mulReadyAt = 0;
        foreach (readyAt[i]) readyAt[i] = 0;
        void'($urandom(32'hb7d0));
        repeat (5) @(posedge clk);
        rstN <= 1'b1;
        repeat (3) @(posedge clk);

        prog.push_back(iType(OpLw, 1, 2));
        prog.push_back(rType(2, 3, 4, FnAdd));
        runProgram("loadThenAlu");
        prog.push_back(iType(OpLw, 1, 5));
        prog.push_back(iType(OpBeq, 5, 0));
        runProgram("loadThenBranch");
        prog.push_back(rType(1, 2, 6, FnSub));
        prog.push_back(iType(OpBne, 1, 6));
        runProgram("aluThenBranch");
        prog.push_back(rType(1, 2, 0, FnMult));
        prog.push_back(rType(0, 0, 7, FnMflo));
        runProgram("multThenMflo");
        prog.push_back(rType(1, 2, 0, FnDiv));
        prog.push_back(rType(0, 0, 8, FnMfhi));
        runProgram("divThenMfhi");
        prog.push_back(rType(1, 2, 0, FnMultu));
        prog.push_back(rType(3, 4, 0, FnDivu));
        prog.push_back(rType(9, 0, 0, FnMthi));
        runProgram("mulDivChain");

        for (int i = 0; i < RandomCount; i++) begin
            prog.push_back(randomInstr());
        end
        runProgram("random");

        checks++;
        assert (creditCount == issuedCount && credits == QueueDepth) else begin
            $display("Credits returned %0d do not match %0d issued", creditCount, issuedCount);
            errors++;
        end
        $display("Checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule
